/* nkmd_cpu.f */
logic/nkmd_isa_pkg.sv
logic/nkmd_cfg_pkg.sv
logic/nkmd_pipe_bus.sv
logic/nkmd_cpu_if.sv
logic/nkmd_cpu_dcd.sv
logic/nkmd_cpu_regfile.sv
logic/nkmd_cpu_ex.sv
logic/nkmd_cpu_wb.sv
logic/nkmd_cpu.sv
tests/nkmd_cpu_checker.sv
tests/nkmd_cpu_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP ?= nkmd_cpu_tb
FLIST ?= nkmd_cpu.f
OBJ_DIR ?= obj_dir
LOG ?= sim.log
PASS_MSG ?= All checks passed
VFLAGS ?= --binary --timing --assert --timescale 1ns/1ps
RUN_ARGS ?= +verilator+error+limit+1000

SRCS := $(wildcard logic/*.sv tests/*.sv)
BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR) -o V$(TOP)

run: $(BIN)
	./$(BIN) $(RUN_ARGS) | tee $(LOG)
	grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* tests/nkmd_cpu_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module nkmd_cpu_tb;
    import nkmd_isa_pkg::*;
    import nkmd_cfg_pkg::*;

    localparam logic [31:0] SEED = 32'hdb035b36;
    localparam int LOAD_ADDR = 47;

    logic clk;
    logic rst;
    word_t p_data_i;
    word_t p_addr_o;
    word_t r_data_i;
    word_t r_data_o;
    word_t r_addr_o;
    logic r_we_o;

    word_t prog [$];
    word_t exp_addr [$];
    word_t exp_data [$];
    word_t mem [64];

    int store_idx;
    int mismatches;
    int store_errs;
    int cycles;
    int limit;
    bit timed_out;

    nkmd_cpu dut0 (
        .clk(clk), .rst(rst),
        .p_data_i(p_data_i), .p_addr_o(p_addr_o),
        .r_data_i(r_data_i), .r_data_o(r_data_o), .r_addr_o(r_addr_o), .r_we_o(r_we_o));

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic word_t encode(opcode_e op, alu_op_e fn, regsel_t rd, regsel_t rs,
                                     regsel_t rt, int imm);
        logic [IMM_W-1:0] imm_f;
        imm_f = imm[IMM_W-1:0];
        return {op, rd, rs, rt, fn, imm_f};
    endfunction

    // Reference results for each ALU function
    function automatic word_t alu_expect(alu_op_e fn, word_t a, word_t b);
        case (fn)
            ALU_ADD: return a + b;
            ALU_SUB: return a - b;
            ALU_AND: return a & b;
            ALU_OR: return a | b;
            ALU_XOR: return a ^ b;
            ALU_SHL: return a << b[4:0];
            ALU_SHR: return a >> b[4:0];
            default: return b;
        endcase
    endfunction

    // Squashed stores go into the program but not into the expected table
    task automatic emit_store(int off, regsel_t src, word_t data, bit on_bus);
        prog.push_back(encode(OP_ST, ALU_ADD, REG_ZERO, REG_ZERO, src, off));
        if (on_bus) begin
            exp_addr.push_back(word_t'(off));
            exp_data.push_back(data);
        end
    endtask

    task automatic build_program();
        alu_op_e fn;
        bit shift;
        // r1 = 1234, r2 = -7, r3 = 5
        prog.push_back(encode(OP_ALUI, ALU_ADD, 4'd1, REG_ZERO, REG_ZERO, 1234));
        prog.push_back(encode(OP_ALUI, ALU_ADD, 4'd2, REG_ZERO, REG_ZERO, -7));
        prog.push_back(encode(OP_ALUI, ALU_ADD, 4'd3, REG_ZERO, REG_ZERO, 5));
        for (int i = 0; i < 8; i++) begin
            fn = alu_op_e'(3'(i));
            shift = fn inside {ALU_SHL, ALU_SHR};
            prog.push_back(encode(OP_ALU, fn, regsel_t'(4 + i), 4'd1, shift ? 4'd3 : 4'd2, 0));
        end
        for (int i = 0; i < 8; i++) begin
            fn = alu_op_e'(3'(i));
            shift = fn inside {ALU_SHL, ALU_SHR};
            emit_store(16 + i, regsel_t'(4 + i), alu_expect(fn, 1234, shift ? 5 : -7), 1'b1);
        end
        // Immediate form reuses r4..r11
        for (int i = 0; i < 8; i++) begin
            fn = alu_op_e'(3'(i));
            shift = fn inside {ALU_SHL, ALU_SHR};
            prog.push_back(encode(OP_ALUI, fn, regsel_t'(4 + i), 4'd1, REG_ZERO,
                shift ? 3 : -100));
        end
        for (int i = 0; i < 8; i++) begin
            fn = alu_op_e'(3'(i));
            shift = fn inside {ALU_SHL, ALU_SHR};
            emit_store(24 + i, regsel_t'(4 + i), alu_expect(fn, 1234, shift ? 3 : -100), 1'b1);
        end
        // Write to r0 is dropped
        prog.push_back(encode(OP_ALUI, ALU_ADD, REG_ZERO, REG_ZERO, REG_ZERO, 99));
        prog.push_back(word_t'(0));
        emit_store(40, REG_ZERO, word_t'(0), 1'b1);
        // Load with a negative offset, then store it back
        prog.push_back(encode(OP_ALUI, ALU_ADD, 4'd12, REG_ZERO, REG_ZERO, LOAD_ADDR + 3));
        prog.push_back(word_t'(0));
        prog.push_back(encode(OP_LD, ALU_ADD, 4'd13, 4'd12, REG_ZERO, -3));
        prog.push_back(word_t'(0));
        emit_store(41, 4'd13, mem[LOAD_ADDR], 1'b1);
        // JMP and taken BZ each skip two stores
        prog.push_back(encode(OP_JMP, ALU_ADD, REG_ZERO, REG_ZERO, REG_ZERO, 3));
        emit_store(60, 4'd1, word_t'(0), 1'b0);
        emit_store(60, 4'd1, word_t'(0), 1'b0);
        prog.push_back(encode(OP_BZ, ALU_ADD, REG_ZERO, REG_ZERO, REG_ZERO, 3));
        emit_store(61, 4'd1, word_t'(0), 1'b0);
        emit_store(61, 4'd1, word_t'(0), 1'b0);
        // r1 is nonzero, so no branch
        prog.push_back(encode(OP_BZ, ALU_ADD, REG_ZERO, REG_ZERO, 4'd1, 3));
        emit_store(42, 4'd1, word_t'(1234), 1'b1);
        emit_store(43, 4'd3, word_t'(5), 1'b1);
        // Next slot still sees the old r14
        prog.push_back(encode(OP_ALUI, ALU_ADD, 4'd14, REG_ZERO, REG_ZERO, 77));
        emit_store(44, 4'd14, word_t'(0), 1'b1);
        emit_store(45, 4'd14, word_t'(77), 1'b1);
    endtask

    function automatic word_t fetch_word(word_t addr);
        if (addr < prog.size()) begin
            return prog[addr];
        end
        return '0;
    endfunction

    function automatic bit program_done();
        return store_idx == exp_addr.size() && p_addr_o >= prog.size() + 4;
    endfunction

    always @(posedge clk) begin
        #2;
        p_data_i = fetch_word(p_addr_o);
        r_data_i = mem[r_addr_o[5:0]];
    end

    task automatic check_store();
        if (r_we_o === 1'b1) begin
            if (store_idx >= exp_addr.size()) begin
                $display("Unexpected store of %h to address %h", r_data_o, r_addr_o);
                store_errs++;
            end else begin
                if (r_addr_o !== exp_addr[store_idx]) begin
                    $display("MISMATCH r_addr_o: got %h, expected %h",
                        r_addr_o, exp_addr[store_idx]);
                    mismatches++;
                end
                if (r_data_o !== exp_data[store_idx]) begin
                    $display("MISMATCH r_data_o: got %h, expected %h",
                        r_data_o, exp_data[store_idx]);
                    mismatches++;
                end
                store_idx++;
            end
            mem[r_addr_o[5:0]] = r_data_o;
        end
    endtask

    initial begin
        rst = 1'b1;
        p_data_i = '0;
        r_data_i = '0;
        store_idx = 0;
        mismatches = 0;
        store_errs = 0;
        cycles = 0;
        timed_out = 1'b0;
        void'($urandom(SEED));
        for (int i = 0; i < 64; i++) begin
            mem[i] = $urandom;
        end
        build_program();
        limit = 4 * prog.size() + 40;

        repeat (4) @(posedge clk);
        #2;
        rst = 1'b0;

        @(negedge clk);
        if (p_addr_o !== RESET_PC) begin
            $display("MISMATCH p_addr_o: got %h, expected %h", p_addr_o, RESET_PC);
            mismatches++;
        end
        if (r_we_o !== 1'b0) begin
            $display("MISMATCH r_we_o: got %h, expected %h", r_we_o, 1'b0);
            mismatches++;
        end
        check_store();

        while (!program_done() && cycles < limit) begin
            @(negedge clk);
            cycles++;
            check_store();
        end
        if (!program_done()) begin
            $display("Timeout: program not finished after %0d cycles", cycles);
            timed_out = 1'b1;
        end
        if (store_idx < exp_addr.size()) begin
            $display("Missing stores: saw %0d of %0d", store_idx, exp_addr.size());
            store_errs++;
        end

        $display("Errors: %0d mismatches, %0d store errors, %0d assertion failures, timeout %0d",
            mismatches, store_errs, dut0.checker0.fail_count, timed_out);
        if (mismatches == 0 && store_errs == 0 && dut0.checker0.fail_count == 0
                && !timed_out) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* tests/nkmd_cpu_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module nkmd_cpu_checker (
    input  wire                 clk,
    input  wire                 rst,
    input  nkmd_cfg_pkg::word_t p_addr_i,
    input  wire                 r_we_i,
    input  wire                 redirect_i
);
    import nkmd_cfg_pkg::*;

    int fail_count = 0;

    a_we_known: assert property (@(posedge clk) disable iff (rst) !$isunknown(r_we_i))
        else begin
            $error("r_we_o is unknown");
            fail_count++;
        end

    // No store can be in writeback right after reset
    a_we_low_after_reset: assert property (@(posedge clk) $fell(rst) |-> !r_we_i)
        else begin
            $error("r_we_o high in the first cycle after reset");
            fail_count++;
        end

    // PC steps by one word unless a redirect was taken
    a_pc_step: assert property (@(posedge clk) disable iff (rst)
        !$past(rst) |-> (p_addr_i == $past(p_addr_i) + word_t'(1)) || $past(redirect_i))
        else begin
            $error("p_addr_o changed without a redirect");
            fail_count++;
        end

endmodule

bind nkmd_cpu nkmd_cpu_checker checker0 (
    .clk(clk),
    .rst(rst),
    .p_addr_i(p_addr_o),
    .r_we_i(r_we_o),
    .redirect_i(ex_redirect)
);

`default_nettype wire

/* logic/nkmd_cpu.sv */
`timescale 1ns/1ps
`default_nettype none

module nkmd_cpu (
    input  wire                 clk,
    input  wire                 rst,

    // Program bus
    input  nkmd_cfg_pkg::word_t p_data_i,
    output nkmd_cfg_pkg::word_t p_addr_o,

    // Data bus
    input  nkmd_cfg_pkg::word_t r_data_i,
    output nkmd_cfg_pkg::word_t r_data_o,
    output nkmd_cfg_pkg::word_t r_addr_o,
    output logic                r_we_o
);
    import nkmd_isa_pkg::*;
    import nkmd_cfg_pkg::*;

    word_t if_inst;
    word_t if_pc;
    logic ex_redirect;
    word_t ex_target;
    logic ex_flush;
    logic wb_we;
    regsel_t wb_sel;
    word_t wb_data;

    dcd_bus dcd_link ();
    rf_bus rf_link ();
    ex_bus ex_link ();

    nkmd_cpu_if u_if (
        .clk(clk), .rst(rst),
        .p_data_i(p_data_i), .p_addr_o(p_addr_o),
        .redirect_i(ex_redirect), .target_i(ex_target),
        .inst_o(if_inst), .pc_o(if_pc));

    nkmd_cpu_dcd u_dcd (
        .clk(clk), .rst(rst),
        .inst_i(if_inst), .pc_i(if_pc), .flush_i(ex_flush),
        .dcd(dcd_link.src));

    nkmd_cpu_regfile u_regfile (
        .clk(clk), .rst(rst),
        .dcd(dcd_link.dst), .flush_i(ex_flush),
        .we_i(wb_we), .wsel_i(wb_sel), .wdata_i(wb_data),
        .rf(rf_link.src));

    nkmd_cpu_ex u_ex (
        .clk(clk), .rst(rst),
        .rf(rf_link.dst), .ex(ex_link.src),
        .redirect_o(ex_redirect), .target_o(ex_target), .flush_o(ex_flush));

    nkmd_cpu_wb u_wb (
        .clk(clk), .rst(rst),
        .ex(ex_link.dst),
        .r_data_i(r_data_i), .r_addr_o(r_addr_o), .r_data_o(r_data_o), .r_we_o(r_we_o),
        .we_o(wb_we), .wsel_o(wb_sel), .wdata_o(wb_data));

endmodule

`default_nettype wire

/* logic/nkmd_cpu_wb.sv */
`timescale 1ns/1ps
`default_nettype none

module nkmd_cpu_wb (
    input  wire                     clk,
    input  wire                     rst,

    ex_bus.dst                      ex,

    input  nkmd_cfg_pkg::word_t     r_data_i,
    output nkmd_cfg_pkg::word_t     r_addr_o,
    output nkmd_cfg_pkg::word_t     r_data_o,
    output logic                    r_we_o,

    output logic                    we_o,
    output nkmd_isa_pkg::regsel_t   wsel_o,
    output nkmd_cfg_pkg::word_t     wdata_o
);
    import nkmd_isa_pkg::*;
    import nkmd_cfg_pkg::*;

    logic access;
    logic store;
    word_t addr_q;
    word_t data_q;

    assign access = ex.valid && (ex.op == OP_LD || ex.op == OP_ST);
    assign store = ex.valid && ex.op == OP_ST;

    // Bus lines hold their last value between accesses
    always_ff @(posedge clk) begin
        if (rst) begin
            addr_q <= '0;
        end else if (access) begin
            addr_q <= ex.result;
        end
    end

    always_ff @(posedge clk) begin
        if (store) begin
            data_q <= ex.sdata;
        end
    end

    assign r_addr_o = access ? ex.result : addr_q;
    assign r_data_o = store ? ex.sdata : data_q;
    assign r_we_o = store;

    assign we_o = ex.valid && ex.op inside {OP_ALU, OP_ALUI, OP_LD};
    assign wsel_o = ex.rd;
    assign wdata_o = (ex.op == OP_LD) ? r_data_i : ex.result;

endmodule

`default_nettype wire

/* logic/nkmd_cpu_ex.sv */
`timescale 1ns/1ps
`default_nettype none

module nkmd_cpu_ex (
    input  wire                 clk,
    input  wire                 rst,

    rf_bus.dst                  rf,
    ex_bus.src                  ex,

    output logic                redirect_o,
    output nkmd_cfg_pkg::word_t target_o,
    output logic                flush_o
);
    import nkmd_isa_pkg::*;
    import nkmd_cfg_pkg::*;

    word_t opb;
    word_t alu_out;
    word_t result;
    logic [SHAMT_W-1:0] shamt;

    assign opb = (rf.op == OP_ALUI) ? rf.imm : rf.rtval;
    assign shamt = opb[SHAMT_W-1:0];

    always_comb begin
        case (rf.alusel)
            ALU_ADD: alu_out = rf.rsval + opb;
            ALU_SUB: alu_out = rf.rsval - opb;
            ALU_AND: alu_out = rf.rsval & opb;
            ALU_OR: alu_out = rf.rsval | opb;
            ALU_XOR: alu_out = rf.rsval ^ opb;
            ALU_SHL: alu_out = rf.rsval << shamt;
            ALU_SHR: alu_out = rf.rsval >> shamt;
            default: alu_out = opb;
        endcase
    end

    always_comb begin
        case (rf.op)
            OP_ALU, OP_ALUI: result = alu_out;
            // Address generation
            OP_LD, OP_ST: result = rf.rsval + rf.imm;
            default: result = '0;
        endcase
    end

    // BZ tests rt; both branch forms are pc relative
    assign redirect_o = rf.valid &&
        (rf.op == OP_JMP || (rf.op == OP_BZ && rf.rtval == '0));
    assign target_o = rf.pc + rf.imm;
    assign flush_o = redirect_o;

    always_ff @(posedge clk) begin
        if (rst) begin
            ex.valid <= 1'b0;
        end else begin
            ex.valid <= rf.valid;
        end
    end

    always_ff @(posedge clk) begin
        ex.op <= rf.op;
        ex.rd <= rf.rd;
        ex.result <= result;
        ex.sdata <= rf.rtval;
    end

endmodule

`default_nettype wire

/* logic/nkmd_cpu_regfile.sv */
`timescale 1ns/1ps
`default_nettype none

module nkmd_cpu_regfile (
    input  wire                     clk,
    input  wire                     rst,

    dcd_bus.dst                     dcd,
    input  wire                     flush_i,

    input  wire                     we_i,
    input  nkmd_isa_pkg::regsel_t   wsel_i,
    input  nkmd_cfg_pkg::word_t     wdata_i,

    rf_bus.src                      rf
);
    import nkmd_isa_pkg::*;
    import nkmd_cfg_pkg::*;

    word_t regs [1:NUM_REGS-1];
    word_t rs_val;
    word_t rt_val;

    // Same-cycle writeback wins over the stored value
    function automatic word_t read_reg(regsel_t sel);
        if (sel == REG_ZERO) begin
            return '0;
        end
        if (we_i && wsel_i == sel) begin
            return wdata_i;
        end
        return regs[sel];
    endfunction

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 1; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && wsel_i != REG_ZERO) begin
            regs[wsel_i] <= wdata_i;
        end
    end

    always_comb begin
        rs_val = read_reg(dcd.rs);
        rt_val = read_reg(dcd.rt);
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rf.valid <= 1'b0;
        end else begin
            rf.valid <= dcd.valid && !flush_i;
        end
    end

    always_ff @(posedge clk) begin
        rf.op <= dcd.op;
        rf.alusel <= dcd.alusel;
        rf.rd <= dcd.rd;
        rf.rsval <= rs_val;
        rf.rtval <= rt_val;
        rf.imm <= dcd.imm;
        rf.pc <= dcd.pc;
    end

endmodule

`default_nettype wire

/* logic/nkmd_cpu_dcd.sv */
`timescale 1ns/1ps
`default_nettype none

module nkmd_cpu_dcd (
    input  wire                 clk,
    input  wire                 rst,

    input  nkmd_cfg_pkg::word_t inst_i,
    input  nkmd_cfg_pkg::word_t pc_i,
    input  wire                 flush_i,

    dcd_bus.src                 dcd
);
    import nkmd_isa_pkg::*;
    import nkmd_cfg_pkg::*;

    opcode_e opc;
    logic known;

    assign opc = opcode_e'(inst_i[OPC_LO +: OPC_W]);

    // NOP and undefined opcodes never enter the pipe
    assign known = opc inside {OP_ALU, OP_ALUI, OP_LD, OP_ST, OP_JMP, OP_BZ};

    always_ff @(posedge clk) begin
        if (rst) begin
            dcd.valid <= 1'b0;
        end else begin
            dcd.valid <= known && !flush_i;
        end
    end

    always_ff @(posedge clk) begin
        dcd.op <= opc;
        dcd.alusel <= alu_op_e'(inst_i[ALUSEL_LO +: ALUSEL_W]);
        dcd.rd <= inst_i[RD_LO +: REGSEL_W];
        dcd.rs <= inst_i[RS_LO +: REGSEL_W];
        dcd.rt <= inst_i[RT_LO +: REGSEL_W];
        dcd.imm <= {{(WORD_W-IMM_W){inst_i[IMM_W-1]}}, inst_i[IMM_W-1:0]};
        dcd.pc <= pc_i;
    end

endmodule

`default_nettype wire

/* logic/nkmd_cpu_if.sv */
`timescale 1ns/1ps
`default_nettype none

module nkmd_cpu_if (
    input  wire                 clk,
    input  wire                 rst,

    input  nkmd_cfg_pkg::word_t p_data_i,
    output nkmd_cfg_pkg::word_t p_addr_o,

    input  wire                 redirect_i,
    input  nkmd_cfg_pkg::word_t target_i,

    output nkmd_cfg_pkg::word_t inst_o,
    output nkmd_cfg_pkg::word_t pc_o
);
    import nkmd_cfg_pkg::*;

    word_t pc_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc_q <= RESET_PC;
        end else if (redirect_i) begin
            pc_q <= target_i;
        end else begin
            pc_q <= pc_q + word_t'(1);
        end
    end

    // Program bus answers in the same cycle
    assign p_addr_o = pc_q;
    assign inst_o = p_data_i;
    assign pc_o = pc_q;

endmodule

`default_nettype wire

/* logic/nkmd_pipe_bus.sv */
`timescale 1ns/1ps
`default_nettype none

// Decode to register read
interface dcd_bus;
    import nkmd_isa_pkg::*;
    import nkmd_cfg_pkg::*;

    logic valid;
    opcode_e op;
    alu_op_e alusel;
    regsel_t rd;
    regsel_t rs;
    regsel_t rt;
    word_t imm;
    word_t pc;

    modport src (output valid, op, alusel, rd, rs, rt, imm, pc);
    modport dst (input valid, op, alusel, rd, rs, rt, imm, pc);
endinterface

// Register read to execute
interface rf_bus;
    import nkmd_isa_pkg::*;
    import nkmd_cfg_pkg::*;

    logic valid;
    opcode_e op;
    alu_op_e alusel;
    regsel_t rd;
    word_t rsval;
    word_t rtval;
    word_t imm;
    word_t pc;

    modport src (output valid, op, alusel, rd, rsval, rtval, imm, pc);
    modport dst (input valid, op, alusel, rd, rsval, rtval, imm, pc);
endinterface

// Execute to writeback
interface ex_bus;
    import nkmd_isa_pkg::*;
    import nkmd_cfg_pkg::*;

    logic valid;
    opcode_e op;
    regsel_t rd;
    word_t result;
    word_t sdata;

    modport src (output valid, op, rd, result, sdata);
    modport dst (input valid, op, rd, result, sdata);
endinterface

`default_nettype wire

/* logic/nkmd_cfg_pkg.sv */
`default_nettype none

package nkmd_cfg_pkg;

    localparam int WORD_W = 32;

    typedef logic [WORD_W-1:0] word_t;

    // Shift amount covers one word
    localparam int SHAMT_W = $clog2(WORD_W);

    localparam int NUM_REGS = 16;

    // Program bus is word addressed
    localparam word_t RESET_PC = word_t'(0);

endpackage

`default_nettype wire

/* logic/nkmd_isa_pkg.sv */
`default_nettype none

package nkmd_isa_pkg;

    // Field positions within the instruction word
    localparam int OPC_W = 4;
    localparam int OPC_LO = 28;
    localparam int REGSEL_W = 4;
    localparam int RD_LO = 24;
    localparam int RS_LO = 20;
    localparam int RT_LO = 16;
    localparam int ALUSEL_W = 3;
    localparam int ALUSEL_LO = 13;
    localparam int IMM_W = 13;

    typedef logic [REGSEL_W-1:0] regsel_t;

    // Selector 0 is hardwired to zero
    localparam regsel_t REG_ZERO = regsel_t'(0);

    typedef enum logic [OPC_W-1:0] {
        OP_NOP  = 4'h0,
        OP_ALU  = 4'h1,
        OP_ALUI = 4'h2,
        OP_LD   = 4'h3,
        OP_ST   = 4'h4,
        OP_JMP  = 4'h5,
        OP_BZ   = 4'h6
    } opcode_e;

    typedef enum logic [ALUSEL_W-1:0] {
        ALU_ADD   = 3'd0,
        ALU_SUB   = 3'd1,
        ALU_AND   = 3'd2,
        ALU_OR    = 3'd3,
        ALU_XOR   = 3'd4,
        ALU_SHL   = 3'd5,
        ALU_SHR   = 3'd6,
        // Second operand straight through
        ALU_PASSB = 3'd7
    } alu_op_e;

endpackage

`default_nettype wire
